// ==== common/regex_pkg.sv ====
package regex_pkg;

    // character and memory geometry
    localparam int CHARACTER_WIDTH   = 8;
    localparam int MEMORY_WIDTH      = 16;
    localparam int MEMORY_ADDR_WIDTH = 11;
    localparam int REG_WIDTH         = 32;
    localparam int PC_WIDTH          = 8;
    // pointer bits that pick a character inside a word
    localparam int C_ADDR_OFFSET     = 1;

    localparam logic [CHARACTER_WIDTH-1:0] CHARACTER_TERMINATOR = '0;
    localparam logic [PC_WIDTH-1:0]        START_PC             = '0;

    // instruction layout
    localparam int OPCODE_WIDTH    = 4;
    localparam int INSTR_PAD_WIDTH = MEMORY_WIDTH - OPCODE_WIDTH - CHARACTER_WIDTH;

    // every other encoding is reserved and traps
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_MATCH  = 4'd1,
        OP_ANY    = 4'd2,
        OP_JMP    = 4'd3,
        OP_ACCEPT = 4'd4
    } opcode_t;

    // low byte sits at the even byte address
    typedef struct packed {
        logic [CHARACTER_WIDTH-1:0] high_char;
        logic [CHARACTER_WIDTH-1:0] low_char;
    } char_pair_t;

    // operand is the character for MATCH, the target for JMP
    typedef struct packed {
        opcode_t                    opcode;
        logic [INSTR_PAD_WIDTH-1:0] pad;
        logic [CHARACTER_WIDTH-1:0] operand;
    } instruction_t;

    // one memory word, read as string data or as program
    typedef union packed {
        char_pair_t   chars;
        instruction_t instr;
    } memory_word_u;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_FIRST,
        EXEC,
        FETCH_NEXT,
        NEXT_IN_WORD,
        DONE_ACCEPT,
        DONE_REJECT,
        ERROR
    } state_t;

endpackage

// ==== logic/memory_arbiter.sv ====
`timescale 1ns/1ns

module memory_arbiter (
    input  logic                                   in_0_valid,
    input  logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] in_0_addr,
    output logic                                   in_0_ready,
    input  logic                                   in_1_valid,
    input  logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] in_1_addr,
    output logic                                   in_1_ready,
    output logic                                   out_valid,
    output logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] out_addr,
    input  logic                                   out_ready
);
    import regex_pkg::*;

    // either requester can raise the shared port
    assign out_valid = in_0_valid | in_1_valid;

    // input 0 wins whenever it asks
    assign out_addr = in_0_valid ? in_0_addr : in_1_addr;

    // grant follows the port ready
    assign in_0_ready = out_ready;
    // input 1 only gets through when input 0 is quiet
    assign in_1_ready = out_ready & ~in_0_valid;

endmodule

// ==== logic/char_cursor.sv ====
`timescale 1ns/1ns

module char_cursor (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [regex_pkg::REG_WIDTH-1:0]         start_cc_pointer,
    input  logic                                   load,
    input  logic                                   advance,
    input  logic                                   word_latch,
    input  regex_pkg::memory_word_u                memory_data,
    output logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] cc_addr,
    output logic                                   crosses_word,
    output logic [regex_pkg::CHARACTER_WIDTH-1:0]   current_character,
    output logic                                   cur_is_even_character
);
    import regex_pkg::*;

    logic [REG_WIDTH-1:0] cc_pointer;
    logic [REG_WIDTH-1:0] cc_pointer_inc;
    memory_word_u         string_word;

    assign cc_pointer_inc = cc_pointer + REG_WIDTH'(1);

    // next character lives in another word when the word bit flips
    assign crosses_word = cc_pointer[C_ADDR_OFFSET] != cc_pointer_inc[C_ADDR_OFFSET];

    // start word while loading, otherwise the word after the pointer
    assign cc_addr = load ? start_cc_pointer[C_ADDR_OFFSET +: MEMORY_ADDR_WIDTH]
                          : cc_pointer_inc[C_ADDR_OFFSET +: MEMORY_ADDR_WIDTH];

    // byte pointer and parity flag
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cc_pointer            <= '0;
            cur_is_even_character <= 1'b1;
        end
        else if (load)
        begin
            cc_pointer            <= start_cc_pointer;
            cur_is_even_character <= ~start_cc_pointer[0];
        end
        else if (advance)
        begin
            cc_pointer            <= cc_pointer_inc;
            cur_is_even_character <= ~cur_is_even_character;
        end
    end

    // string word taken from the broadcast bus one cycle after the grant
    always_ff @(posedge clk)
    begin
        if (word_latch)
            string_word <= memory_data;
    end

    // even address reads the low byte
    assign current_character = cur_is_even_character ? string_word.chars.low_char
                                                     : string_word.chars.high_char;

endmodule

// ==== logic/regex_control_fsm.sv ====
`timescale 1ns/1ns

module regex_control_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start_ready,
    output logic start_valid,
    output logic cc_valid,
    input  logic cc_ready,
    output logic load,
    output logic advance,
    output logic word_latch,
    input  logic crosses_word,
    output logic go,
    output logic restart,
    output logic flush,
    input  logic consumed,
    input  logic accepts,
    input  logic rejects,
    input  logic illegal,
    output logic finish,
    output logic accept,
    output logic error
);
    import regex_pkg::*;

    state_t state;
    state_t next_state;
    // a consumed character is still waiting for its word grant
    logic   char_wait;
    logic   next_char_wait;
    logic   need_char;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= IDLE;
            char_wait <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            char_wait <= next_char_wait;
        end
    end

    assign need_char = consumed | char_wait;
    // error is sticky since ERROR only leaves on reset
    assign error     = state == ERROR;

    always_comb
    begin
        next_state     = state;
        next_char_wait = char_wait;
        start_valid    = 1'b0;
        cc_valid       = 1'b0;
        load           = 1'b0;
        advance        = 1'b0;
        word_latch     = 1'b0;
        go             = 1'b0;
        restart        = 1'b0;
        flush          = 1'b0;
        finish         = 1'b0;
        accept         = 1'b0;
        case (state)
            IDLE:
            begin
                // cursor tracks the host pointer and asks for its word
                load     = 1'b1;
                cc_valid = start_ready;
                if (start_ready && cc_ready)
                begin
                    start_valid = 1'b1;
                    next_state  = FETCH_FIRST;
                end
            end
            FETCH_FIRST:
            begin
                word_latch = 1'b1;
                restart    = 1'b1;
                next_state = EXEC;
            end
            EXEC:
            begin
                // engine is held while the next character is pending
                go = ~char_wait;
                if (illegal)
                    next_state = ERROR;
                else if (accepts)
                    next_state = DONE_ACCEPT;
                else if (rejects)
                    next_state = DONE_REJECT;
                else if (need_char && crosses_word)
                begin
                    cc_valid = 1'b1;
                    if (cc_ready)
                    begin
                        advance        = 1'b1;
                        next_char_wait = 1'b0;
                        next_state     = FETCH_NEXT;
                    end
                    else
                        next_char_wait = 1'b1;
                end
                else if (need_char)
                begin
                    // same word, only the pointer moves
                    advance    = 1'b1;
                    next_state = NEXT_IN_WORD;
                end
            end
            FETCH_NEXT:
            begin
                word_latch = 1'b1;
                next_state = EXEC;
            end
            NEXT_IN_WORD:
                next_state = EXEC;
            DONE_ACCEPT:
            begin
                finish     = 1'b1;
                accept     = 1'b1;
                flush      = 1'b1;
                next_state = IDLE;
            end
            DONE_REJECT:
            begin
                finish     = 1'b1;
                flush      = 1'b1;
                next_state = IDLE;
            end
            default:
                next_state = ERROR;
        endcase
    end

endmodule

// ==== engine/match_engine.sv ====
`timescale 1ns/1ns

module match_engine (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   flush,
    input  logic                                   go,
    input  logic                                   restart,
    input  logic [regex_pkg::CHARACTER_WIDTH-1:0]   current_character,
    output logic                                   instr_valid,
    output logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] instr_addr,
    input  logic                                   instr_ready,
    input  regex_pkg::memory_word_u                memory_data,
    output logic                                   consumed,
    output logic                                   accepts,
    output logic                                   rejects,
    output logic                                   illegal
);
    import regex_pkg::*;

    logic [PC_WIDTH-1:0] pc;
    logic [PC_WIDTH-1:0] next_pc;
    // instruction word arrives on the bus this cycle
    logic                fetch_pending;
    logic                halted;
    logic                char_ok;
    logic                set_accepts;
    logic                set_rejects;
    logic                set_illegal;

    // once a verdict is held the engine stops fetching
    assign halted = accepts | rejects | illegal;

    assign instr_valid = go & ~fetch_pending & ~halted;
    assign instr_addr  = MEMORY_ADDR_WIDTH'(pc);

    // the terminator is never consumed
    assign char_ok = current_character != CHARACTER_TERMINATOR;

    // decode runs in the cycle after the grant
    always_comb
    begin
        next_pc     = pc;
        consumed    = 1'b0;
        set_accepts = 1'b0;
        set_rejects = 1'b0;
        set_illegal = 1'b0;
        if (fetch_pending)
        begin
            case (memory_data.instr.opcode)
                OP_MATCH:
                begin
                    if (char_ok && current_character == memory_data.instr.operand)
                    begin
                        consumed = 1'b1;
                        next_pc  = pc + PC_WIDTH'(1);
                    end
                    else
                        set_rejects = 1'b1;
                end
                OP_ANY:
                begin
                    if (char_ok)
                    begin
                        consumed = 1'b1;
                        next_pc  = pc + PC_WIDTH'(1);
                    end
                    else
                        set_rejects = 1'b1;
                end
                OP_JMP:
                    next_pc = memory_data.instr.operand;
                OP_ACCEPT:
                    set_accepts = 1'b1;
                default:
                    set_illegal = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            pc            <= START_PC;
            fetch_pending <= 1'b0;
            accepts       <= 1'b0;
            rejects       <= 1'b0;
            illegal       <= 1'b0;
        end
        else
        begin
            if (restart)
                pc <= START_PC;
            else
                pc <= next_pc;
            // pending for exactly one cycle after each grant
            fetch_pending <= instr_valid & instr_ready;
            // verdicts stay up until the run is flushed
            if (set_accepts)
                accepts <= 1'b1;
            if (set_rejects)
                rejects <= 1'b1;
            if (set_illegal)
                illegal <= 1'b1;
        end
    end

endmodule

// ==== logic/regex_coprocessor.sv ====
`timescale 1ns/1ns

module regex_coprocessor (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   memory_ready,
    output logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] memory_addr,
    input  logic [regex_pkg::MEMORY_WIDTH-1:0]      memory_data,
    output logic                                   memory_valid,
    input  logic                                   start_ready,
    input  logic [regex_pkg::REG_WIDTH-1:0]         start_cc_pointer,
    output logic                                   start_valid,
    output logic                                   finish,
    output logic                                   accept,
    output logic                                   error
);
    import regex_pkg::*;

    // character fetch, arbiter input 0
    logic                         cc_valid;
    logic                         cc_ready;
    logic [MEMORY_ADDR_WIDTH-1:0] cc_addr;
    // instruction fetch, arbiter input 1
    logic                         instr_valid;
    logic                         instr_ready;
    logic [MEMORY_ADDR_WIDTH-1:0] instr_addr;
    // cursor controls
    logic                         load;
    logic                         advance;
    logic                         word_latch;
    logic                         crosses_word;
    logic [CHARACTER_WIDTH-1:0]   current_character;
    // engine controls and results
    logic                         go;
    logic                         restart;
    logic                         flush;
    logic                         consumed;
    logic                         accepts;
    logic                         rejects;
    logic                         illegal;

    regex_control_fsm u_fsm (
        .clk          (clk),
        .reset        (reset),
        .start_ready  (start_ready),
        .start_valid  (start_valid),
        .cc_valid     (cc_valid),
        .cc_ready     (cc_ready),
        .load         (load),
        .advance      (advance),
        .word_latch   (word_latch),
        .crosses_word (crosses_word),
        .go           (go),
        .restart      (restart),
        .flush        (flush),
        .consumed     (consumed),
        .accepts      (accepts),
        .rejects      (rejects),
        .illegal      (illegal),
        .finish       (finish),
        .accept       (accept),
        .error        (error)
    );

    // parity flag only steers the character select inside the cursor
    char_cursor u_cursor (
        .clk                   (clk),
        .reset                 (reset),
        .start_cc_pointer      (start_cc_pointer),
        .load                  (load),
        .advance               (advance),
        .word_latch            (word_latch),
        .memory_data           (memory_data),
        .cc_addr               (cc_addr),
        .crosses_word          (crosses_word),
        .current_character     (current_character),
        .cur_is_even_character ()
    );

    match_engine u_engine (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .go                (go),
        .restart           (restart),
        .current_character (current_character),
        .instr_valid       (instr_valid),
        .instr_addr        (instr_addr),
        .instr_ready       (instr_ready),
        .memory_data       (memory_data),
        .consumed          (consumed),
        .accepts           (accepts),
        .rejects           (rejects),
        .illegal           (illegal)
    );

    // character fetch outranks instruction fetch
    memory_arbiter u_arbiter (
        .in_0_valid (cc_valid),
        .in_0_addr  (cc_addr),
        .in_0_ready (cc_ready),
        .in_1_valid (instr_valid),
        .in_1_addr  (instr_addr),
        .in_1_ready (instr_ready),
        .out_valid  (memory_valid),
        .out_addr   (memory_addr),
        .out_ready  (memory_ready)
    );

endmodule

// ==== bench/regex_coprocessor_sva.sv ====
`timescale 1ns/1ns

module regex_coprocessor_sva (
    input logic                                   clk,
    input logic                                   reset,
    input logic                                   memory_valid,
    input logic                                   memory_ready,
    input logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] memory_addr,
    input logic                                   finish,
    input logic                                   accept,
    input logic                                   error
);

    // number of assertion failures so far
    int failure_count = 0;

    // finish is a single-cycle pulse
    finish_one_cycle: assert property (@(posedge clk) disable iff (reset)
        finish |=> !finish)
    else
    begin
        failure_count = failure_count + 1;
        $error("finish stayed high for more than one cycle");
    end

    accept_with_finish: assert property (@(posedge clk) disable iff (reset)
        accept |-> finish)
    else
    begin
        failure_count = failure_count + 1;
        $error("accept seen without finish");
    end

    // a stalled request keeps its address
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        memory_valid && !memory_ready |=> memory_valid && $stable(memory_addr))
    else
    begin
        failure_count = failure_count + 1;
        $error("memory request changed while stalled");
    end

    error_sticky: assert property (@(posedge clk) disable iff (reset)
        error |=> error)
    else
    begin
        failure_count = failure_count + 1;
        $error("error dropped before reset");
    end

endmodule

bind regex_coprocessor regex_coprocessor_sva u_sva (
    .clk          (clk),
    .reset        (reset),
    .memory_valid (memory_valid),
    .memory_ready (memory_ready),
    .memory_addr  (memory_addr),
    .finish       (finish),
    .accept       (accept),
    .error        (error)
);

// ==== bench/regex_coprocessor_tb.sv ====
`timescale 1ns/1ns

module regex_coprocessor_tb;
    import regex_pkg::*;

    localparam int NUM_ROWS          = 7;
    localparam int MAX_INSTR         = 4;
    localparam int RESET_CYCLES      = 5;
    localparam int CYCLES_PER_ROW    = 400;
    localparam int ERROR_HOLD_CYCLES = 8;
    localparam int OUT_REJECT        = 0;
    localparam int OUT_ACCEPT        = 1;
    localparam int OUT_ERROR         = 2;
    // opcode 7 is reserved, so a runaway pc traps
    localparam logic [MEMORY_WIDTH-1:0] PAD_WORD = 16'h7000;

    logic                         clk;
    logic                         reset            = 1'b1;
    logic                         memory_ready     = 1'b0;
    logic [MEMORY_WIDTH-1:0]      memory_data      = '0;
    logic                         start_ready      = 1'b0;
    logic [REG_WIDTH-1:0]         start_cc_pointer = '0;
    logic [MEMORY_ADDR_WIDTH-1:0] memory_addr;
    logic                         memory_valid;
    logic                         start_valid;
    logic                         finish;
    logic                         accept;
    logic                         error;

    integer seed = 9670;
    int     current_row;
    int     row_count = 0;

    logic [MEMORY_WIDTH-1:0] memory_words [2**MEMORY_ADDR_WIDTH];
    // stimulus table, one entry per run
    logic [MEMORY_WIDTH-1:0] prog_table    [NUM_ROWS*MAX_INSTR];
    string                   text_table    [NUM_ROWS];
    logic [REG_WIDTH-1:0]    addr_table    [NUM_ROWS];
    int                      outcome_table [NUM_ROWS];

    regex_coprocessor dut (
        .clk              (clk),
        .reset            (reset),
        .memory_ready     (memory_ready),
        .memory_addr      (memory_addr),
        .memory_data      (memory_data),
        .memory_valid     (memory_valid),
        .start_ready      (start_ready),
        .start_cc_pointer (start_cc_pointer),
        .start_valid      (start_valid),
        .finish           (finish),
        .accept           (accept),
        .error            (error)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory with random back-pressure returns the word the cycle after the transfer
    always @(posedge clk)
    begin
        memory_ready <= ($random(seed) & 3) != 0;
        if (memory_valid && memory_ready)
            memory_data <= memory_words[memory_addr];
    end

    initial
    begin
        repeat (NUM_ROWS * CYCLES_PER_ROW) @(posedge clk);
        $display("watchdog expired: row %0d did not end within the cycle budget", current_row);
        $display("test failed");
        $fatal(1, "run stopped by the watchdog");
    end

    // any bound assertion failure ends the run at once
    initial
    begin
        wait (dut.u_sva.failure_count != 0);
        $display("bound assertion failed in row %0d at time %0t", current_row, $time);
        $display("test failed");
        $fatal(1, "stopped at the first assertion failure");
    end

    function automatic logic [MEMORY_WIDTH-1:0] encode_match(input logic [7:0] ch);
        return {OP_MATCH, 4'h0, ch};
    endfunction

    function automatic logic [MEMORY_WIDTH-1:0] encode_jmp(input logic [7:0] target);
        return {OP_JMP, 4'h0, target};
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED row %0d %s: got 0x%0h, expected 0x%0h",
                     current_row, name, actual, expected);
            $display("test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic add_row(input logic [MEMORY_WIDTH-1:0] i0, input logic [MEMORY_WIDTH-1:0] i1,
                           input logic [MEMORY_WIDTH-1:0] i2, input logic [MEMORY_WIDTH-1:0] i3,
                           input string text, input logic [REG_WIDTH-1:0] addr, input int outcome);
        prog_table[row_count*MAX_INSTR + 0] = i0;
        prog_table[row_count*MAX_INSTR + 1] = i1;
        prog_table[row_count*MAX_INSTR + 2] = i2;
        prog_table[row_count*MAX_INSTR + 3] = i3;
        text_table[row_count]    = text;
        addr_table[row_count]    = addr;
        outcome_table[row_count] = outcome;
        row_count = row_count + 1;
    endtask

    task automatic write_byte(input logic [REG_WIDTH-1:0] byte_addr, input logic [7:0] value);
        logic [MEMORY_ADDR_WIDTH-1:0] word_addr;
        word_addr = byte_addr[MEMORY_ADDR_WIDTH:1];
        // odd byte addresses hold the high byte
        if (byte_addr[0])
            memory_words[word_addr][15:8] = value;
        else
            memory_words[word_addr][7:0] = value;
    endtask

    // whole image rebuilt while the DUT is held in reset
    task automatic load_memory(input int row);
        int i;
        for (i = 0; i < 2**MEMORY_ADDR_WIDTH; i++)
            memory_words[i] = 16'hE000 | MEMORY_WIDTH'(i);
        for (i = 0; i < MAX_INSTR; i++)
            memory_words[START_PC + i] = prog_table[row*MAX_INSTR + i];
        for (i = 0; i < text_table[row].len(); i++)
            write_byte(addr_table[row] + i, text_table[row][i]);
        // terminator follows the last character
        write_byte(addr_table[row] + text_table[row].len(), CHARACTER_TERMINATOR);
    endtask

    task automatic run_row(input int row);
        int   start_pulses;
        int   finish_pulses;
        logic accept_seen;
        logic error_seen;
        logic ended;
        start_pulses  = 0;
        finish_pulses = 0;
        accept_seen   = 1'b0;
        error_seen    = 1'b0;
        ended         = 1'b0;
        reset       <= 1'b1;
        start_ready <= 1'b0;
        @(posedge clk);
        load_memory(row);
        repeat (RESET_CYCLES - 1) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        start_cc_pointer <= addr_table[row];
        start_ready      <= 1'b1;
        // request stays up until the DUT takes it
        while (!ended)
        begin
            @(posedge clk);
            if (start_valid)
            begin
                start_pulses = start_pulses + 1;
                start_ready <= 1'b0;
            end
            if (finish)
            begin
                finish_pulses = finish_pulses + 1;
                accept_seen   = accept;
                ended         = 1'b1;
            end
            if (error)
            begin
                error_seen = 1'b1;
                ended      = 1'b1;
            end
        end
        compare("start_valid pulses", start_pulses, 1);
        if (outcome_table[row] == OUT_ERROR)
        begin
            compare("finish pulses", finish_pulses, 0);
            // error must hold with no finish until the next reset
            repeat (ERROR_HOLD_CYCLES)
            begin
                @(posedge clk);
                compare("error", error, 1);
                compare("finish", finish, 0);
            end
        end
        else
        begin
            compare("error", error_seen, 0);
            compare("finish pulses", finish_pulses, 1);
            compare("accept", accept_seen, outcome_table[row] == OUT_ACCEPT);
        end
    endtask

    initial
    begin
        // literal match, accepted
        add_row(encode_match("a"), encode_match("b"), {OP_ACCEPT, 12'h000}, PAD_WORD,
                "abc", 32'h100, OUT_ACCEPT);
        // second character differs
        add_row(encode_match("a"), encode_match("b"), {OP_ACCEPT, 12'h000}, PAD_WORD,
                "ax", 32'h121, OUT_REJECT);
        // ANY refuses the terminator
        add_row({OP_ANY, 12'h000}, {OP_ANY, 12'h000}, {OP_ACCEPT, 12'h000}, PAD_WORD,
                "k", 32'h140, OUT_REJECT);
        // jump over MATCH z, string at an odd address
        add_row(encode_jmp(8'd2), encode_match("z"), encode_match("q"), {OP_ACCEPT, 12'h000},
                "q", 32'h163, OUT_ACCEPT);
        // opcode 0 is reserved
        add_row(encode_match("e"), 16'h0000, PAD_WORD, PAD_WORD,
                "e", 32'h181, OUT_ERROR);
        // loop that runs into the terminator
        add_row({OP_ANY, 12'h000}, encode_match("y"), encode_jmp(8'd0), PAD_WORD,
                "xyzy", 32'h1a3, OUT_REJECT);
        add_row(encode_match("h"), {OP_ANY, 12'h000}, {OP_ANY, 12'h000}, {OP_ACCEPT, 12'h000},
                "hey", 32'h1c2, OUT_ACCEPT);
        for (current_row = 0; current_row < row_count; current_row++)
            run_row(current_row);
        if (dut.u_sva.failure_count != 0)
        begin
            $display("bound assertions failed %0d times", dut.u_sva.failure_count);
            $display("test failed");
            $fatal(1, "assertion failures during the run");
        end
        else
        begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== regex_coprocessor.f ====
common/regex_pkg.sv
logic/memory_arbiter.sv
logic/char_cursor.sv
logic/regex_control_fsm.sv
engine/match_engine.sv
logic/regex_coprocessor.sv
bench/regex_coprocessor_sva.sv
bench/regex_coprocessor_tb.sv

// ==== Bender.yml ====
package:
  name: regex_coprocessor

sources:
  - common/regex_pkg.sv
  - logic/memory_arbiter.sv
  - logic/char_cursor.sv
  - logic/regex_control_fsm.sv
  - engine/match_engine.sv
  - logic/regex_coprocessor.sv
  - target: test
    files:
      - bench/regex_coprocessor_sva.sv
      - bench/regex_coprocessor_tb.sv
